/* filelist.f */
+incdir+hw
hw/scenePkg.sv
hw/gameFlow.sv
hw/walkAnimator.sv
hw/pixelAddressGen.sv
hw/colorMixer.sv
hw/sceneRenderer.sv
sim/sceneRendererTb.sv

/* hw/colorMixer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "scene_cfg.svh"

module colorMixer
	import scenePkg::*;
(
	input wire logic Clk,
	input wire logic rst,
	input wire gameStateT gameState,
	input wire pixelTagT tag,
	input wire logic [`IDX_W-1:0] titleIndex,
	input wire logic [`IDX_W-1:0] mapIndex,
	input wire logic [`IDX_W-1:0] spriteIndex,
	output rgbT pixel
);

	rgbT spritePalette [2**`IDX_W];
	rgbT scenePalette [2**`IDX_W];
	pixelTagT tagQ;

	initial begin
		$readmemh("hw/spritePalette.mem", spritePalette);
		$readmemh("hw/scenePalette.mem", scenePalette);
	end

	// Tag lines up with the indices coming back from the image memories
	always_ff @(posedge Clk) begin
		if (rst) begin
			tagQ <= '0;
			pixel <= '0;
		end else begin
			tagQ <= tag;
			if (!tagQ.displayEnable) begin
				pixel <= '0;
			end else if (gameState == title) begin
				pixel <= scenePalette[titleIndex];
			end else if (!tagQ.inMap) begin
				pixel <= '0;
			end else if (tagQ.spriteHere && spriteIndex != '0) begin
				// Index 0 is transparent
				pixel <= spritePalette[spriteIndex];
			end else begin
				pixel <= scenePalette[mapIndex];
			end
		end
	end

endmodule

`default_nettype wire

/* hw/gameFlow.sv */
`timescale 1ns/1ps
`default_nettype none

`include "scene_cfg.svh"

module gameFlow
	import scenePkg::*;
(
	input wire logic Clk,
	input wire logic rst,
	input wire logic frameTick,
	input wire logic [7:0] keycode,
	output gameStateT gameState,
	output logic enterWorld
);

	logic startGame;

	// Key is only sampled on a frame tick from the title screen
	assign startGame = frameTick && (gameState == title) && (keycode == `ENTER_KEY);

	always_ff @(posedge Clk) begin
		if (rst) begin
			gameState <= title;
			enterWorld <= 1'b0;
		end else begin
			enterWorld <= startGame;
			if (startGame) begin
				gameState <= overworld;
			end
		end
	end

endmodule

`default_nettype wire

/* hw/pixelAddressGen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "scene_cfg.svh"

module pixelAddressGen
	import scenePkg::*;
(
	input wire logic [10:0] drawX,
	input wire logic [10:0] drawY,
	input wire logic displayEnable,
	input wire walkStateT walk,
	input wire camPosT cam,
	output logic [`ADDR_W-1:0] titleAddr,
	output logic [`ADDR_W-1:0] mapAddr,
	output logic [`ADDR_W-1:0] spriteAddr,
	output pixelTagT tag
);

	logic signed [13:0] worldX;
	logic signed [13:0] worldY;
	logic [12:0] cellX;
	logic [12:0] cellY;
	logic worldNeg;
	logic spriteHere;
	logic [10:0] spriteRow;
	logic [10:0] spriteCol;
	logic [3:0] frameBase;
	logic [3:0] frame;

	assign titleAddr = `ADDR_W'((drawY / `TITLE_SCALE) * `TITLE_W + drawX / `TITLE_SCALE);

	assign worldX = $signed({3'b000, drawX}) + 14'(cam.x);
	assign worldY = $signed({3'b000, drawY}) + 14'(cam.y);
	assign worldNeg = worldX[13] || worldY[13];
	assign cellX = worldX[12:0] >> $clog2(`MAP_CELL);
	assign cellY = worldY[12:0] >> $clog2(`MAP_CELL);

	assign mapAddr = worldNeg ? '0 : `ADDR_W'(cellY * `MAP_W + cellX);

	assign spriteHere = (drawX >= `SPRITE_X0) && (drawX <= `SPRITE_X1) &&
		(drawY >= `SPRITE_Y0) && (drawY <= `SPRITE_Y1);
	assign spriteRow = drawY - 11'(`SPRITE_Y0);
	assign spriteCol = drawX - 11'(`SPRITE_X0);

	// First frame of each facing in the sheet, order is move1, rest, move2
	always_comb begin
		unique case (walk.facing)
			down: frameBase = 4'd0;
			left: frameBase = 4'd3;
			up: frameBase = 4'd6;
			right: frameBase = 4'd9;
		endcase
		unique case (walk.phase)
			move1: frame = frameBase;
			move2: frame = frameBase + 4'd2;
			default: frame = frameBase + 4'd1;
		endcase
	end

	assign spriteAddr = spriteHere ?
		`ADDR_W'(spriteRow * `SHEET_W + spriteCol + `SPRITE_W * frame) : '0;

	assign tag.displayEnable = displayEnable;
	assign tag.inMap = !worldNeg && (cellX < `MAP_W) && (cellY < `MAP_H);
	assign tag.spriteHere = spriteHere;

endmodule

`default_nettype wire

/* hw/scenePalette.mem */
// One 24-bit RGB value per line (red, green, blue), palette index 0 to 15
1A1C2C
5D275D
B13E53
EF7D57
FFCD75
A7F070
38B764
257179
29366F
3B5DC9
41A6F6
73EFF7
F4F4F4
94B0C2
566C86
333C57

/* hw/scenePkg.sv */
`default_nettype none

package scenePkg;

	typedef enum logic {
		title,
		overworld
	} gameStateT;

	typedef enum logic [1:0] {
		up    = 2'd0,
		right = 2'd1,
		down  = 2'd2,
		left  = 2'd3
	} dirT;

	// Walk cycle order
	typedef enum logic [1:0] {
		rest1,
		move1,
		rest2,
		move2
	} stepPhaseT;

	typedef struct packed {
		dirT facing;
		stepPhaseT phase;
	} walkStateT;

	// Top-left corner of the view in screen pixels
	typedef struct packed {
		logic signed [12:0] x;
		logic signed [12:0] y;
	} camPosT;

	typedef struct packed {
		logic displayEnable;
		logic inMap;
		logic spriteHere;
	} pixelTagT;

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgbT;

endpackage

`default_nettype wire

/* hw/sceneRenderer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "scene_cfg.svh"

module sceneRenderer
	import scenePkg::*;
(
	input wire logic Clk,
	input wire logic rst,
	input wire logic frameTick,
	input wire logic [7:0] keycode,
	input wire logic moving,
	input wire dirT direction,
	input wire logic [10:0] drawX,
	input wire logic [10:0] drawY,
	input wire logic displayEnable,
	input wire logic [`IDX_W-1:0] titleIndex,
	input wire logic [`IDX_W-1:0] mapIndex,
	input wire logic [`IDX_W-1:0] spriteIndex,
	output logic [`ADDR_W-1:0] titleAddr,
	output logic [`ADDR_W-1:0] mapAddr,
	output logic [`ADDR_W-1:0] spriteAddr,
	output rgbT pixel
);

	gameStateT gameState;
	logic enterWorld;
	walkStateT walk;
	camPosT cam;
	pixelTagT tag;

	gameFlow gameFlow_i (
		.Clk(Clk),
		.rst(rst),
		.frameTick(frameTick),
		.keycode(keycode),
		.gameState(gameState),
		.enterWorld(enterWorld)
	);

	walkAnimator walkAnimator_i (
		.Clk(Clk),
		.rst(rst),
		.frameTick(frameTick),
		.moving(moving),
		.enterWorld(enterWorld),
		.gameState(gameState),
		.direction(direction),
		.walk(walk),
		.cam(cam)
	);

	pixelAddressGen pixelAddressGen_i (
		.drawX(drawX),
		.drawY(drawY),
		.displayEnable(displayEnable),
		.walk(walk),
		.cam(cam),
		.titleAddr(titleAddr),
		.mapAddr(mapAddr),
		.spriteAddr(spriteAddr),
		.tag(tag)
	);

	colorMixer colorMixer_i (
		.Clk(Clk),
		.rst(rst),
		.gameState(gameState),
		.tag(tag),
		.titleIndex(titleIndex),
		.mapIndex(mapIndex),
		.spriteIndex(spriteIndex),
		.pixel(pixel)
	);

endmodule

`default_nettype wire

/* hw/scene_cfg.svh */
`ifndef SCENE_CFG_SVH
`define SCENE_CFG_SVH

// Beam extent
`define SCREEN_W 640
`define SCREEN_H 480

// Fixed character window on screen
`define SPRITE_X0 311
`define SPRITE_X1 329
`define SPRITE_Y0 340
`define SPRITE_Y1 368

// Sprite sheet, 12 frames in one row
`define SPRITE_W 19
`define SHEET_W 228

// Map in cells of 4x4 screen pixels
`define MAP_W 320
`define MAP_H 240
`define MAP_CELL 4

`define TITLE_W 320
`define TITLE_SCALE 2

`define CAM_X_MIN (-311)
`define CAM_X_MAX 951
`define CAM_Y_MIN (-340)
`define CAM_Y_MAX 594
`define CAM_START_X 100
`define CAM_START_Y 100

`define ENTER_KEY 8'h2C
`define STEP_DELAY 8

`define ADDR_W 19
`define IDX_W 4

`endif

/* hw/spritePalette.mem */
// One 24-bit RGB value per line (red, green, blue), palette index 0 to 15
000000
FF0040
131313
1B1B1B
272727
3D3D3D
5D5D5D
858585
B4B4B4
FFFFFF
C7CFDD
92A1B9
657392
424C6E
2A2F4E
F9C22B

/* hw/walkAnimator.sv */
`timescale 1ns/1ps
`default_nettype none

`include "scene_cfg.svh"

module walkAnimator
	import scenePkg::*;
(
	input wire logic Clk,
	input wire logic rst,
	input wire logic frameTick,
	input wire logic moving,
	input wire logic enterWorld,
	input wire gameStateT gameState,
	input wire dirT direction,
	output walkStateT walk,
	output camPosT cam
);

	localparam int delayBits = $clog2(`STEP_DELAY);
	localparam logic [delayBits-1:0] delayLast = delayBits'(`STEP_DELAY - 1);
	localparam logic signed [12:0] camXMin = 13'(`CAM_X_MIN);
	localparam logic signed [12:0] camXMax = 13'(`CAM_X_MAX);
	localparam logic signed [12:0] camYMin = 13'(`CAM_Y_MIN);
	localparam logic signed [12:0] camYMax = 13'(`CAM_Y_MAX);
	localparam logic signed [12:0] camStartX = 13'(`CAM_START_X);
	localparam logic signed [12:0] camStartY = 13'(`CAM_START_Y);

	logic [delayBits-1:0] stepDelay;
	logic walkTick;

	assign walkTick = frameTick && (gameState == overworld);

	always_ff @(posedge Clk) begin
		if (rst) begin
			walk.facing <= up;
			walk.phase <= rest1;
			stepDelay <= '0;
			cam.x <= camStartX;
			cam.y <= camStartY;
		end else if (enterWorld) begin
			cam.x <= camStartX;
			cam.y <= camStartY;
		end else if (walkTick) begin
			if (!moving) begin
				walk.phase <= rest1;
			end else if (direction != walk.facing) begin
				// Turn in place
				walk.facing <= direction;
				walk.phase <= rest1;
			end else begin
				if (stepDelay == '0) begin
					walk.phase <= stepPhaseT'(walk.phase + 2'd1);
				end
				stepDelay <= (stepDelay == delayLast) ? '0 : stepDelay + 1'b1;

				// Camera scroll, clamped at the world edges
				unique case (direction)
					up: begin
						if (cam.y > camYMin) begin
							cam.y <= cam.y - 13'sd1;
						end
					end
					down: begin
						if (cam.y <= camYMax) begin
							cam.y <= cam.y + 13'sd1;
						end
					end
					right: begin
						if (cam.x <= camXMax) begin
							cam.x <= cam.x + 13'sd1;
						end
					end
					left: begin
						if (cam.x > camXMin) begin
							cam.x <= cam.x - 13'sd1;
						end
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --top-module sceneRendererTb -f filelist.f \
	-o simv > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }
./obj_dir/simv > sim.log 2>&1
cat sim.log
! grep -q "TEST FAIL" sim.log && grep -q "TEST PASS" sim.log \
	&& exit 0 \
	|| { echo "simulation failed"; exit 1; }

/* sim/sceneRendererTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "scene_cfg.svh"

module sceneRendererTb
	import scenePkg::*;
();

	localparam int drainLimit = 8;

	logic Clk = 1'b0;
	logic rst;
	logic frameTick;
	logic [7:0] keycode;
	logic moving;
	dirT direction;
	logic [10:0] drawX;
	logic [10:0] drawY;
	logic displayEnable;
	logic [`IDX_W-1:0] titleIndex = '0;
	logic [`IDX_W-1:0] mapIndex = '0;
	logic [`IDX_W-1:0] spriteIndex = '0;
	logic [`ADDR_W-1:0] titleAddr;
	logic [`ADDR_W-1:0] mapAddr;
	logic [`ADDR_W-1:0] spriteAddr;
	rgbT pixel;

	// Image memory model state
	logic [`IDX_W-1:0] titleCap = '0;
	logic [`IDX_W-1:0] mapCap = '0;
	logic [`IDX_W-1:0] spriteCap = '0;

	rgbT scenePal [2**`IDX_W];
	rgbT spritePal [2**`IDX_W];

	// Reference model state
	gameStateT refGame;
	logic refEnter;
	dirT refFacing;
	stepPhaseT refPhase;
	int refDelay;
	int refCamX;
	int refCamY;

	logic checksOn = 1'b0;
	logic [`ADDR_W-1:0] expTitleAddr;
	logic [`ADDR_W-1:0] expMapAddr;
	logic [`ADDR_W-1:0] expSpriteAddr;
	rgbT pixQ0;
	rgbT pixQ1;
	rgbT pixQ2;

	int addrErrors = 0;
	int pixelErrors = 0;
	int otherErrors = 0;
	int unsigned rngState = 76;

	sceneRenderer sceneRenderer_i (
		.Clk(Clk),
		.rst(rst),
		.frameTick(frameTick),
		.keycode(keycode),
		.moving(moving),
		.direction(direction),
		.drawX(drawX),
		.drawY(drawY),
		.displayEnable(displayEnable),
		.titleIndex(titleIndex),
		.mapIndex(mapIndex),
		.spriteIndex(spriteIndex),
		.titleAddr(titleAddr),
		.mapAddr(mapAddr),
		.spriteAddr(spriteAddr),
		.pixel(pixel)
	);

	always #2 Clk = ~Clk;

	initial begin
		$readmemh("hw/scenePalette.mem", scenePal);
		$readmemh("hw/spritePalette.mem", spritePal);
	end

	// Each memory returns the low address bits one cycle later
	always @(posedge Clk) begin
		titleCap <= titleAddr[`IDX_W-1:0];
		mapCap <= mapAddr[`IDX_W-1:0];
		spriteCap <= spriteAddr[`IDX_W-1:0];
	end

	always @(negedge Clk) begin
		titleIndex <= titleCap;
		mapIndex <= mapCap;
		spriteIndex <= spriteCap;
	end

	task automatic addrMismatch(input string name, input logic [`ADDR_W-1:0] got,
			input logic [`ADDR_W-1:0] want);
		addrErrors++;
		$display("[FAIL] %0d ns %s got %0h expected %0h", $time, name, got, want);
	endtask

	task automatic pixelMismatch(input rgbT got, input rgbT want);
		pixelErrors++;
		$display("[FAIL] %0d ns pixel got %06h expected %06h", $time, got, want);
	endtask

	titleAddrMatch: assert property (@(posedge Clk) disable iff (rst)
		checksOn |-> titleAddr == expTitleAddr)
		else addrMismatch("titleAddr", $sampled(titleAddr), expTitleAddr);

	mapAddrMatch: assert property (@(posedge Clk) disable iff (rst)
		checksOn |-> mapAddr == expMapAddr)
		else addrMismatch("mapAddr", $sampled(mapAddr), expMapAddr);

	spriteAddrMatch: assert property (@(posedge Clk) disable iff (rst)
		checksOn |-> spriteAddr == expSpriteAddr)
		else addrMismatch("spriteAddr", $sampled(spriteAddr), expSpriteAddr);

	// pixQ2 holds the prediction for the beam two edges back
	pixelMatch: assert property (@(posedge Clk) disable iff (rst)
		checksOn |-> pixel == pixQ2)
		else pixelMismatch($sampled(pixel), pixQ2);

	function automatic int unsigned nextRand();
		rngState = rngState * 32'd1103515245 + 32'd12345;
		return rngState >> 16;
	endfunction

	// Sheet frame from the facing table, rest2 shows the rest frame
	function automatic int frameOf(input dirT facing, input stepPhaseT phase);
		int restF;
		int move1F;
		int move2F;
		case (facing)
			down: begin
				restF = 1;
				move1F = 0;
				move2F = 2;
			end
			left: begin
				restF = 4;
				move1F = 3;
				move2F = 5;
			end
			up: begin
				restF = 7;
				move1F = 6;
				move2F = 8;
			end
			default: begin
				restF = 10;
				move1F = 9;
				move2F = 11;
			end
		endcase
		if (phase == move1) begin
			return move1F;
		end else if (phase == move2) begin
			return move2F;
		end
		return restF;
	endfunction

	function automatic stepPhaseT nextPhase(input stepPhaseT phase);
		case (phase)
			rest1: return move1;
			move1: return rest2;
			rest2: return move2;
			default: return rest1;
		endcase
	endfunction

	function automatic rgbT expectedPixel(input logic de, input logic inMap,
			input logic inWindow, input logic [`IDX_W-1:0] titleIdx,
			input logic [`IDX_W-1:0] mapIdx, input logic [`IDX_W-1:0] spriteIdx);
		if (!de) begin
			return '0;
		end else if (refGame == title) begin
			return scenePal[titleIdx];
		end else if (!inMap) begin
			return '0;
		end else if (inWindow && spriteIdx != '0) begin
			return spritePal[spriteIdx];
		end
		return scenePal[mapIdx];
	endfunction

	// Game flow and walk rules, as they apply at the next rising edge
	task automatic updateModel(input logic tick, input logic [7:0] key, input logic mv,
			input dirT dir);
		logic startGame;
		startGame = tick && refGame == title && key == `ENTER_KEY;
		if (refEnter) begin
			refCamX = `CAM_START_X;
			refCamY = `CAM_START_Y;
		end else if (tick && refGame == overworld) begin
			if (!mv) begin
				refPhase = rest1;
			end else if (dir != refFacing) begin
				refFacing = dir;
				refPhase = rest1;
			end else begin
				if (refDelay == 0) begin
					refPhase = nextPhase(refPhase);
				end
				refDelay = (refDelay + 1) % `STEP_DELAY;
				if (dir == up && refCamY > `CAM_Y_MIN) begin
					refCamY--;
				end else if (dir == down && refCamY <= `CAM_Y_MAX) begin
					refCamY++;
				end else if (dir == right && refCamX <= `CAM_X_MAX) begin
					refCamX++;
				end else if (dir == left && refCamX > `CAM_X_MIN) begin
					refCamX--;
				end
			end
		end
		refEnter = startGame;
		if (startGame) begin
			refGame = overworld;
		end
	endtask

	task automatic driveCycle(input logic tick, input logic [7:0] key, input logic mv,
			input dirT dir, input logic [10:0] x, input logic [10:0] y, input logic de);
		int wx;
		int wy;
		logic worldNeg;
		logic inMap;
		logic inWindow;
		frameTick = tick;
		keycode = key;
		moving = mv;
		direction = dir;
		drawX = x;
		drawY = y;
		displayEnable = de;

		wx = int'(x) + refCamX;
		wy = int'(y) + refCamY;
		worldNeg = wx < 0 || wy < 0;
		inMap = !worldNeg && wx / `MAP_CELL < `MAP_W && wy / `MAP_CELL < `MAP_H;
		inWindow = x >= `SPRITE_X0 && x <= `SPRITE_X1 && y >= `SPRITE_Y0 && y <= `SPRITE_Y1;
		expTitleAddr = `ADDR_W'((int'(y) / `TITLE_SCALE) * `TITLE_W + int'(x) / `TITLE_SCALE);
		expMapAddr = worldNeg ? '0 :
			`ADDR_W'((wy / `MAP_CELL) * `MAP_W + wx / `MAP_CELL);
		expSpriteAddr = !inWindow ? '0 : `ADDR_W'((int'(y) - `SPRITE_Y0) * `SHEET_W +
			(int'(x) - `SPRITE_X0) + `SPRITE_W * frameOf(refFacing, refPhase));

		updateModel(tick, key, mv, dir);

		pixQ2 = pixQ1;
		pixQ1 = pixQ0;
		pixQ0 = expectedPixel(de, inMap, inWindow, expTitleAddr[`IDX_W-1:0],
			expMapAddr[`IDX_W-1:0], expSpriteAddr[`IDX_W-1:0]);
	endtask

	task automatic step(input logic tick, input logic [7:0] key, input logic mv,
			input dirT dir, input logic [10:0] x, input logic [10:0] y, input logic de);
		@(negedge Clk);
		driveCycle(tick, key, mv, dir, x, y, de);
	endtask

	task automatic randomBeams(input int count, input logic windowOnly);
		int unsigned x;
		int unsigned y;
		logic de;
		for (int i = 0; i < count; i++) begin
			if (windowOnly) begin
				x = `SPRITE_X0 + nextRand() % (`SPRITE_X1 - `SPRITE_X0 + 1);
				y = `SPRITE_Y0 + nextRand() % (`SPRITE_Y1 - `SPRITE_Y0 + 1);
				de = 1'b1;
			end else begin
				x = nextRand() % `SCREEN_W;
				y = nextRand() % `SCREEN_H;
				de = (nextRand() % 8) != 0;
			end
			step(1'b0, 8'h00, 1'b0, refFacing, 11'(x), 11'(y), de);
		end
	endtask

	task automatic tickOnce(input logic [7:0] key, input logic mv, input dirT dir);
		step(1'b1, key, mv, dir, 11'(nextRand() % `SCREEN_W), 11'(nextRand() % `SCREEN_H),
			1'b1);
	endtask

	task automatic drainPipe();
		int waited;
		waited = 0;
		do begin
			step(1'b0, 8'h00, 1'b0, refFacing, 11'd0, 11'd0, 1'b0);
			waited++;
		end while ((waited < 3 || pixel != '0) && waited < drainLimit);
		if (pixel != '0) begin
			otherErrors++;
			$display("pixel did not go black within %0d cycles of blanking", drainLimit);
		end
	endtask

	initial begin
		logic [7:0] key;
		rst = 1'b1;
		frameTick = 1'b0;
		keycode = 8'h00;
		moving = 1'b0;
		direction = up;
		drawX = '0;
		drawY = '0;
		displayEnable = 1'b0;
		repeat (16) @(negedge Clk);

		rst = 1'b0;
		refGame = title;
		refEnter = 1'b0;
		refFacing = up;
		refPhase = rest1;
		refDelay = 0;
		refCamX = `CAM_START_X;
		refCamY = `CAM_START_Y;
		// Pixel stays black until the first beam comes through
		pixQ0 = '0;
		pixQ1 = '0;
		checksOn = 1'b1;
		driveCycle(1'b0, 8'h00, 1'b0, up, 11'd0, 11'd0, 1'b0);

		// Title screen
		randomBeams(150, 1'b0);
		for (int i = 0; i < 6; i++) begin
			key = 8'(nextRand());
			if (key == `ENTER_KEY) begin
				key = 8'h2B;
			end
			tickOnce(key, 1'b0, up);
			randomBeams(10, 1'b0);
		end

		// World entry
		tickOnce(`ENTER_KEY, 1'b0, up);
		// Tick in the entry cycle loses to the camera load
		tickOnce(8'h00, 1'b1, right);
		randomBeams(100, 1'b0);
		randomBeams(40, 1'b1);

		// Walk right, then stop
		tickOnce(8'h00, 1'b1, right);
		for (int i = 0; i < 20; i++) begin
			tickOnce(8'h00, 1'b1, right);
			randomBeams(6, 1'b1);
			randomBeams(2, 1'b0);
		end
		tickOnce(8'h00, 1'b0, right);
		randomBeams(20, 1'b1);

		// Turns toward random directions
		for (int i = 0; i < 8; i++) begin
			tickOnce(8'h00, 1'b1, dirT'(2'(nextRand() % 4)));
			randomBeams(8, 1'b1);
			randomBeams(4, 1'b0);
		end

		// Camera runs into the left and top limits
		for (int i = 0; i < 480; i++) begin
			tickOnce(8'h00, 1'b1, left);
			randomBeams(1, 1'b0);
		end
		for (int i = 0; i < 480; i++) begin
			tickOnce(8'h00, 1'b1, up);
			randomBeams(1, 1'b0);
		end
		randomBeams(200, 1'b0);
		randomBeams(60, 1'b1);

		drainPipe();
		@(posedge Clk);
		@(negedge Clk);

		$display("errors: address %0d, pixel %0d, other %0d",
			addrErrors, pixelErrors, otherErrors);
		if (addrErrors + pixelErrors + otherErrors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
